// File: source/mem_sys_pkg.sv
package mem_sys_pkg;

    // Bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    // Bank organisation
    localparam int BANK_COUNT = 4;
    localparam int BANK_SEL_W = 2;
    localparam int BANK_WORDS = 256;
    localparam int BANK_IDX_W = 8;

    // Address split: byte offset, then bank select, then word index in the bank
    localparam int BYTE_OFF_W = 2;
    localparam int BANK_LSB   = BYTE_OFF_W;
    localparam int IDX_LSB    = BANK_LSB + BANK_SEL_W;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [STRB_W-1:0] wstrb;
        logic              we;
    } bus_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic              ack;   // Single-cycle, rdata valid only here
    } bus_rsp_t;

    typedef struct packed {
        logic [BANK_IDX_W-1:0] index;
        logic [DATA_W-1:0]     wdata;
        logic [STRB_W-1:0]     wstrb;
        logic                  we;
    } bank_req_t;

    typedef enum logic {
        OWNER_FETCH = 1'b0,
        OWNER_DATA  = 1'b1
    } owner_t;

endpackage

// File: source/bus_arbiter.sv
`timescale 1ns/100ps

module bus_arbiter (
    input  logic                                 sys_clk,
    input  logic                                 rst_i,
    input  logic                                 fetch_cyc_i,
    input  logic [mem_sys_pkg::ADDR_W-1:0]       fetch_addr_i,
    input  logic                                 data_cyc_i,
    input  mem_sys_pkg::bus_req_t                data_req_i,
    input  logic                                 done_i,
    output logic [mem_sys_pkg::BANK_COUNT-1:0]   bank_stb_o,
    output mem_sys_pkg::bank_req_t               bank_req_o,
    output logic [mem_sys_pkg::BANK_SEL_W-1:0]   sel_bank_o,
    output mem_sys_pkg::owner_t                  sel_owner_o
);

    logic                                 busy_q;
    mem_sys_pkg::owner_t                  last_owner_q;  // Current owner while busy
    logic [mem_sys_pkg::BANK_SEL_W-1:0]   sel_bank_q;
    logic [mem_sys_pkg::BANK_COUNT-1:0]   bank_stb_q;
    mem_sys_pkg::bank_req_t               bank_req_q;

    mem_sys_pkg::bus_req_t                fetch_req;
    mem_sys_pkg::bus_req_t                win_req;
    mem_sys_pkg::owner_t                  winner;
    logic                                 grant;
    logic [mem_sys_pkg::BANK_SEL_W-1:0]   win_bank;
    logic [mem_sys_pkg::BANK_IDX_W-1:0]   win_index;

    // Fetch port is read-only
    always_comb begin
        fetch_req       = '0;
        fetch_req.addr  = fetch_addr_i;
        fetch_req.wdata = '0;
        fetch_req.wstrb = '0;
        fetch_req.we    = 1'b0;
    end

    // Round-robin pick, only while idle
    always_comb begin
        winner = last_owner_q;
        grant  = 1'b0;
        if (!busy_q) begin
            if (fetch_cyc_i && data_cyc_i) begin
                grant = 1'b1;
                if (last_owner_q == mem_sys_pkg::OWNER_FETCH) begin
                    winner = mem_sys_pkg::OWNER_DATA;
                end else begin
                    winner = mem_sys_pkg::OWNER_FETCH;
                end
            end else if (fetch_cyc_i) begin
                grant  = 1'b1;
                winner = mem_sys_pkg::OWNER_FETCH;
            end else if (data_cyc_i) begin
                grant  = 1'b1;
                winner = mem_sys_pkg::OWNER_DATA;
            end
        end
    end

    always_comb begin
        if (winner == mem_sys_pkg::OWNER_DATA) begin
            win_req = data_req_i;
        end else begin
            win_req = fetch_req;
        end
    end

    // Word-interleaved decode, upper address bits alias
    assign win_bank  = win_req.addr[mem_sys_pkg::BANK_LSB +: mem_sys_pkg::BANK_SEL_W];
    assign win_index = win_req.addr[mem_sys_pkg::IDX_LSB +: mem_sys_pkg::BANK_IDX_W];

    always_ff @(posedge sys_clk) begin
        if (rst_i) begin
            busy_q       <= 1'b0;
            last_owner_q <= mem_sys_pkg::OWNER_DATA;  // Fetch wins first
            sel_bank_q   <= '0;
            bank_stb_q   <= '0;
        end else begin
            bank_stb_q <= '0;                         // Strobe is a single pulse
            if (grant) begin
                busy_q               <= 1'b1;
                last_owner_q         <= winner;
                sel_bank_q           <= win_bank;
                bank_stb_q[win_bank] <= 1'b1;
            end else if (done_i) begin
                busy_q <= 1'b0;                       // Owner's cyc ignored this cycle
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (grant) begin
            bank_req_q.index <= win_index;
            bank_req_q.wdata <= win_req.wdata;
            bank_req_q.wstrb <= win_req.wstrb;
            bank_req_q.we    <= win_req.we;
        end
    end

    assign bank_stb_o  = bank_stb_q;
    assign bank_req_o  = bank_req_q;
    assign sel_bank_o  = sel_bank_q;
    assign sel_owner_o = last_owner_q;

endmodule

// File: source/mem_bank.sv
`timescale 1ns/100ps

module mem_bank (
    input  logic                             sys_clk,
    input  logic                             rst_i,
    input  logic                             stb_i,
    input  mem_sys_pkg::bank_req_t           req_i,
    output logic [mem_sys_pkg::DATA_W-1:0]   rdata_o,
    output logic                             ack_o
);

    logic [mem_sys_pkg::DATA_W-1:0] mem [mem_sys_pkg::BANK_WORDS];
    logic [mem_sys_pkg::DATA_W-1:0] rdata_q;
    logic                           ack_q;

    // Byte-lane writes under strobe
    always_ff @(posedge sys_clk) begin
        if (stb_i && req_i.we) begin
            for (int b = 0; b < mem_sys_pkg::STRB_W; b++) begin
                if (req_i.wstrb[b]) begin
                    mem[req_i.index][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
                end
            end
        end
    end

    // Read returns the word before any write on the same edge
    always_ff @(posedge sys_clk) begin
        if (stb_i) begin
            rdata_q <= mem[req_i.index];
        end
    end

    always_ff @(posedge sys_clk) begin
        if (rst_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= stb_i;  // Always answers in one cycle
        end
    end

    assign rdata_o = rdata_q;
    assign ack_o   = ack_q;

endmodule

// File: source/response_mux.sv
`timescale 1ns/100ps

module response_mux (
    input  logic                                                     sys_clk,
    input  logic                                                     rst_i,
    input  logic [mem_sys_pkg::BANK_COUNT-1:0][mem_sys_pkg::DATA_W-1:0] bank_rdata_i,
    input  logic [mem_sys_pkg::BANK_COUNT-1:0]                       bank_ack_i,
    input  logic [mem_sys_pkg::BANK_SEL_W-1:0]                       sel_bank_i,
    input  mem_sys_pkg::owner_t                                      sel_owner_i,
    output mem_sys_pkg::bus_rsp_t                                    fetch_rsp_o,
    output mem_sys_pkg::bus_rsp_t                                    data_rsp_o,
    output logic                                                     done_o
);

    logic                           bank_ack;
    logic [mem_sys_pkg::DATA_W-1:0] rdata_q;
    logic                           fetch_ack_q;
    logic                           data_ack_q;
    logic                           done_q;

    // Only the selected bank can be answering
    assign bank_ack = bank_ack_i[sel_bank_i];

    always_ff @(posedge sys_clk) begin
        if (rst_i) begin
            fetch_ack_q <= 1'b0;
            data_ack_q  <= 1'b0;
            done_q      <= 1'b0;
        end else begin
            fetch_ack_q <= bank_ack && (sel_owner_i == mem_sys_pkg::OWNER_FETCH);
            data_ack_q  <= bank_ack && (sel_owner_i == mem_sys_pkg::OWNER_DATA);
            done_q      <= bank_ack;  // Frees the arbiter with the ack
        end
    end

    always_ff @(posedge sys_clk) begin
        if (bank_ack) begin
            rdata_q <= bank_rdata_i[sel_bank_i];
        end
    end

    // Both ports see the same data, ack tells who owns it
    always_comb begin
        fetch_rsp_o.rdata = rdata_q;
        fetch_rsp_o.ack   = fetch_ack_q;
        data_rsp_o.rdata  = rdata_q;
        data_rsp_o.ack    = data_ack_q;
    end

    assign done_o = done_q;

endmodule

// File: source/mem_subsystem_top.sv
`timescale 1ns/100ps

module mem_subsystem_top (
    input  logic                             sys_clk,
    input  logic                             rst_i,

    // Instruction fetch port, reads only
    input  logic                             fetch_cyc_i,
    input  logic [mem_sys_pkg::ADDR_W-1:0]   fetch_addr_i,
    output mem_sys_pkg::bus_rsp_t            fetch_rsp_o,

    // Load/store port
    input  logic                             data_cyc_i,
    input  mem_sys_pkg::bus_req_t            data_req_i,
    output mem_sys_pkg::bus_rsp_t            data_rsp_o
);

    logic [mem_sys_pkg::BANK_COUNT-1:0]                         bank_stb;
    mem_sys_pkg::bank_req_t                                     bank_req;
    logic [mem_sys_pkg::BANK_SEL_W-1:0]                         sel_bank;
    mem_sys_pkg::owner_t                                        sel_owner;
    logic [mem_sys_pkg::BANK_COUNT-1:0][mem_sys_pkg::DATA_W-1:0] bank_rdata;
    logic [mem_sys_pkg::BANK_COUNT-1:0]                         bank_ack;
    logic                                                       done;

    bus_arbiter u_bus_arbiter (
        .sys_clk      (sys_clk),
        .rst_i        (rst_i),
        .fetch_cyc_i  (fetch_cyc_i),
        .fetch_addr_i (fetch_addr_i),
        .data_cyc_i   (data_cyc_i),
        .data_req_i   (data_req_i),
        .done_i       (done),
        .bank_stb_o   (bank_stb),
        .bank_req_o   (bank_req),
        .sel_bank_o   (sel_bank),
        .sel_owner_o  (sel_owner)
    );

    // Request bus is shared, each bank has its own strobe
    for (genvar i = 0; i < mem_sys_pkg::BANK_COUNT; i++) begin : g_bank
        mem_bank u_mem_bank (
            .sys_clk (sys_clk),
            .rst_i   (rst_i),
            .stb_i   (bank_stb[i]),
            .req_i   (bank_req),
            .rdata_o (bank_rdata[i]),
            .ack_o   (bank_ack[i])
        );
    end

    response_mux u_response_mux (
        .sys_clk      (sys_clk),
        .rst_i        (rst_i),
        .bank_rdata_i (bank_rdata),
        .bank_ack_i   (bank_ack),
        .sel_bank_i   (sel_bank),
        .sel_owner_i  (sel_owner),
        .fetch_rsp_o  (fetch_rsp_o),
        .data_rsp_o   (data_rsp_o),
        .done_o       (done)
    );

endmodule

// File: verification/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Bus response compare, ack and rdata together
task automatic check_rsp(input string name,
                         input mem_sys_pkg::bus_rsp_t expected,
                         input mem_sys_pkg::bus_rsp_t actual);
    if (actual !== expected) begin
        stop_with_failure($sformatf("FAILED %s expected 0x%0h got 0x%0h",
                                    name, expected, actual));
    end
endtask

// Plain data word compare
task automatic check_word(input string name,
                          input logic [mem_sys_pkg::DATA_W-1:0] expected,
                          input logic [mem_sys_pkg::DATA_W-1:0] actual);
    if (actual !== expected) begin
        stop_with_failure($sformatf("FAILED %s expected 0x%0h got 0x%0h",
                                    name, expected, actual));
    end
endtask

// 32-bit Fibonacci LFSR, taps 32 22 2 1, new bit enters at bit 0
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
endfunction

`endif

// File: verification/tb_mem_subsystem.sv
`timescale 1ns/100ps

module tb_mem_subsystem;

    localparam int TIMEOUT_CYCLES = 4000;  // About 300 accesses at 7 cycles plus margin
    localparam int MAX_LATENCY    = 7;     // Loser of a tie waits one full transaction
    localparam int MODEL_WORDS    = mem_sys_pkg::BANK_COUNT * mem_sys_pkg::BANK_WORDS;

    logic                           sys_clk;
    logic                           rst_i;
    logic                           fetch_cyc_i;
    logic [mem_sys_pkg::ADDR_W-1:0] fetch_addr_i;
    mem_sys_pkg::bus_rsp_t          fetch_rsp_o;
    logic                           data_cyc_i;
    mem_sys_pkg::bus_req_t          data_req_i;
    mem_sys_pkg::bus_rsp_t          data_rsp_o;

    logic [mem_sys_pkg::DATA_W-1:0] model_mem [MODEL_WORDS];
    mem_sys_pkg::owner_t            last_served = mem_sys_pkg::OWNER_DATA;  // Fetch wins first
    logic [31:0]                    lfsr_state  = 32'h67cd_6350;
    int                             cycle_count = 0;

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    `include "tb_checks.svh"

    mem_subsystem_top UUT (
        .sys_clk      (sys_clk),
        .rst_i        (rst_i),
        .fetch_cyc_i  (fetch_cyc_i),
        .fetch_addr_i (fetch_addr_i),
        .fetch_rsp_o  (fetch_rsp_o),
        .data_cyc_i   (data_cyc_i),
        .data_req_i   (data_req_i),
        .data_rsp_o   (data_rsp_o)
    );

    initial begin
        sys_clk = 1'b0;
        forever #4 sys_clk = ~sys_clk;
    end

    always @(posedge sys_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_with_failure($sformatf("Timeout, tests still running after %0d cycles",
                                        cycle_count));
        end
    end

    // Only one port may own the single response slot
    always @(negedge sys_clk) begin
        if (fetch_rsp_o.ack && data_rsp_o.ack) begin
            stop_with_failure("Both ports were acknowledged in the same cycle");
        end
    end

    // Bank is word mod BANK_COUNT and index is word / BANK_COUNT mod BANK_WORDS
    function automatic int model_index(input logic [31:0] addr);
        logic [31:0] word;
        int          bank;
        int          index;
        word  = addr >> 2;
        bank  = int'(word % 32'(mem_sys_pkg::BANK_COUNT));
        index = int'((word / 32'(mem_sys_pkg::BANK_COUNT)) % 32'(mem_sys_pkg::BANK_WORDS));
        return index * mem_sys_pkg::BANK_COUNT + bank;
    endfunction

    function automatic logic [31:0] random_word();
        logic [31:0] word;
        word = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr_state = lfsr_next(lfsr_state);  // One step per bit
            word = {word[30:0], lfsr_state[0]};
        end
        return word;
    endfunction

    task automatic data_access(input logic [31:0] addr, input logic [31:0] wdata,
                               input logic [3:0] wstrb, input logic we, output int lat);
        mem_sys_pkg::bus_rsp_t expected;
        data_req_i.addr  = addr;
        data_req_i.wdata = wdata;
        data_req_i.wstrb = wstrb;
        data_req_i.we    = we;
        data_cyc_i       = 1'b1;
        lat              = 0;
        do begin
            @(negedge sys_clk);
            lat++;
            if (lat > MAX_LATENCY) stop_with_failure("No ack on the data port in time");
        end while (data_rsp_o.ack !== 1'b1);
        data_cyc_i  = 1'b0;
        last_served = mem_sys_pkg::OWNER_DATA;
        if (we) begin
            for (int b = 0; b < mem_sys_pkg::STRB_W; b++) begin
                if (wstrb[b]) model_mem[model_index(addr)][b*8 +: 8] = wdata[b*8 +: 8];
            end
        end else begin
            expected.rdata = model_mem[model_index(addr)];
            expected.ack   = 1'b1;
            check_rsp("data_rsp_o", expected, data_rsp_o);
        end
        @(negedge sys_clk);  // Ack must be gone in the idle cycle
        check_word("data_rsp_o.ack after ack", 32'd0, 32'(data_rsp_o.ack));
    endtask

    task automatic data_write(input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [3:0] wstrb, output int lat);
        data_access(addr, wdata, wstrb, 1'b1, lat);
    endtask

    task automatic data_read(input logic [31:0] addr, output int lat);
        data_access(addr, 32'd0, 4'd0, 1'b0, lat);
    endtask

    task automatic fetch_read(input logic [31:0] addr, output int lat);
        mem_sys_pkg::bus_rsp_t expected;
        fetch_addr_i = addr;
        fetch_cyc_i  = 1'b1;
        lat          = 0;
        do begin
            @(negedge sys_clk);
            lat++;
            if (lat > MAX_LATENCY) stop_with_failure("No ack on the fetch port in time");
        end while (fetch_rsp_o.ack !== 1'b1);
        fetch_cyc_i    = 1'b0;
        last_served    = mem_sys_pkg::OWNER_FETCH;
        expected.rdata = model_mem[model_index(addr)];
        expected.ack   = 1'b1;
        check_rsp("fetch_rsp_o", expected, fetch_rsp_o);
        @(negedge sys_clk);
        check_word("fetch_rsp_o.ack after ack", 32'd0, 32'(fetch_rsp_o.ack));
    endtask

    task automatic test_reset_and_single();
        int lat;
        repeat (8) begin
            @(negedge sys_clk);
            check_word("fetch_rsp_o.ack in reset", 32'd0, 32'(fetch_rsp_o.ack));
            check_word("data_rsp_o.ack in reset", 32'd0, 32'(data_rsp_o.ack));
        end
        rst_i = 1'b0;
        repeat (2) begin
            @(negedge sys_clk);
            check_word("fetch_rsp_o.ack after reset", 32'd0, 32'(fetch_rsp_o.ack));
            check_word("data_rsp_o.ack after reset", 32'd0, 32'(data_rsp_o.ack));
        end
        data_write(32'h0000_0040, 32'ha5c3_0f1e, 4'hf, lat);
        check_word("data write ack latency", 32'd3, 32'(lat));
        data_read(32'h0000_0040, lat);
        check_word("data read ack latency", 32'd3, 32'(lat));
    endtask

    task automatic test_byte_strobes();
        int lat;
        data_write(32'h0000_0104, random_word(), 4'hf, lat);
        for (int s = 0; s < 16; s++) begin
            data_write(32'h0000_0104, random_word(), 4'(s), lat);
            data_read(32'h0000_0104, lat);  // Merged word from the model
        end
    endtask

    task automatic test_shared_memory();
        int          lat;
        logic [31:0] addr;
        for (int i = 0; i < 8; i++) begin
            addr = 32'h0000_0200 + 32'(i * 4);
            data_write(addr, random_word(), 4'hf, lat);
            data_write(addr + 32'h20, random_word(), 4'hf, lat);  // Data port holds other data
            fetch_read(addr, lat);
            data_read(addr, lat);  // Fetch left the word alone
        end
    endtask

    task automatic test_interleave();
        int          lat;
        int          k;
        logic [31:0] addr;
        for (int i = 0; i < 64; i++) begin
            data_write(32'h0000_0800 + 32'(i * 4), random_word(), 4'hf, lat);
        end
        for (int j = 0; j < 64; j++) begin
            k = (j * 37 + 11) % 64;  // Odd stride visits every word once
            data_read(32'h0000_0800 + 32'(k * 4), lat);
        end
        for (int i = 0; i < 16; i++) begin
            addr = 32'h0000_0300 + 32'(i * 4);
            data_write(addr + (32'(i + 1) << 12), random_word(), 4'hf, lat);
            data_read(addr, lat);
            fetch_read(addr | 32'hf000_0000, lat);
        end
    endtask

    // Both ports start on the same cycle and the one not served last goes first
    task automatic contend(input logic [31:0] fetch_addr, input logic [31:0] data_addr);
        int lat_fetch;
        int lat_data;
        bit fetch_first;
        fetch_first = (last_served == mem_sys_pkg::OWNER_DATA);
        fork
            fetch_read(fetch_addr, lat_fetch);
            data_read(data_addr, lat_data);
        join
        check_word("fetch latency in tie", fetch_first ? 32'd3 : 32'd7, 32'(lat_fetch));
        check_word("data latency in tie", fetch_first ? 32'd7 : 32'd3, 32'(lat_data));
    endtask

    task automatic test_contention();
        int lat;
        data_read(32'h0000_0800, lat);
        contend(32'h0000_0804, 32'h0000_0808);
        fetch_read(32'h0000_0804, lat);
        contend(32'h0000_080c, 32'h0000_0810);
        contend(32'h0000_0814, 32'h0000_0824);  // Same bank for both
    endtask

    initial begin
        rst_i        = 1'b1;
        fetch_cyc_i  = 1'b0;
        fetch_addr_i = '0;
        data_cyc_i   = 1'b0;
        data_req_i   = '0;
        test_reset_and_single();
        test_byte_strobes();
        test_shared_memory();
        test_interleave();
        test_contention();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: project.f
+incdir+verification
source/mem_sys_pkg.sv
source/bus_arbiter.sv
source/mem_bank.sv
source/response_mux.sv
source/mem_subsystem_top.sv
verification/tb_mem_subsystem.sv

// File: Makefile
# Verilator flow for the memory subsystem testbench
TOP       ?= tb_mem_subsystem
FILELIST  ?= project.f
VERILATOR ?= verilator
BUILD_DIR ?= build
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# A $fatal in the testbench gives a non-zero exit status
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
